// File: verilog/ycr_consts.svh
// --------------------
// Width and depth constants for the data-memory bridge
// --------------------

`ifndef YCR_CONSTS_SVH
`define YCR_CONSTS_SVH

// --------------------
// Core data-memory port
// --------------------

// Byte address from the core
`define YCR_DMEM_AWIDTH 32

// Data word, shared by core and Wishbone
`define YCR_DMEM_DWIDTH 32

// --------------------
// Wishbone side
// --------------------

// One select per byte lane
`define YCR_WB_SEL_W 4

// --------------------
// Reset
// --------------------

// Flops in the interface reset chain
`define YCR_RST_SYNC_STAGES 2

`endif

// File: verilog/ycr_pkg.sv
// --------------------
// Bridge types: command, width and response encodings,
// core and Wishbone structs, data-word union
// --------------------
`include "ycr_consts.svh"

package ycr_pkg;

   // --------------------
   // Encodings
   // --------------------
   typedef enum logic {
      YCR_MEM_CMD_RD = 1'b0,                      // Load
      YCR_MEM_CMD_WR = 1'b1                       // Store
   } mem_cmd_e;

   typedef enum logic [1:0] {
      YCR_MEM_WIDTH_BYTE = 2'd0,                  // 8 bit access
      YCR_MEM_WIDTH_HALF = 2'd1,                  // 16 bit access
      YCR_MEM_WIDTH_WORD = 2'd2                   // 32 bit access
   } mem_width_e;

   typedef enum logic [1:0] {
      YCR_MEM_RESP_IDLE = 2'd0,                   // Nothing to report
      YCR_MEM_RESP_RDY  = 2'd1,                   // Access done
      YCR_MEM_RESP_ERR  = 2'd2                    // Bus error or misaligned
   } mem_resp_e;

   // --------------------
   // Port bundles
   // --------------------
   typedef struct packed {
      mem_cmd_e                        cmd;       // Read or write
      mem_width_e                      width;     // Access size
      logic [`YCR_DMEM_AWIDTH-1:0]     addr;      // Byte address
      logic [`YCR_DMEM_DWIDTH-1:0]     wdata;     // Store data, low aligned
   } core_req_t;

   typedef struct packed {
      logic                            stb;       // Cycle active
      logic [`YCR_DMEM_AWIDTH-1:0]     adr;       // Word aligned address
      logic                            we;        // Write enable
      logic [`YCR_DMEM_DWIDTH-1:0]     dat;       // Lane steered write data
      logic [`YCR_WB_SEL_W-1:0]        sel;       // Byte selects
   } wb_req_t;

   typedef struct packed {
      logic [`YCR_DMEM_DWIDTH-1:0]     dat;       // Raw read word
      logic                            ack;       // Normal termination
      logic                            err;       // Error termination
   } wb_rsp_t;

   // Same word seen whole or per byte lane
   typedef union packed {
      logic [`YCR_DMEM_DWIDTH-1:0]     word;
      logic [`YCR_WB_SEL_W-1:0][7:0]   bytes;
   } dmem_word_u;

endpackage : ycr_pkg

// File: verilog/ycr_reset_sync.sv
// --------------------
// Interface reset synchronizer
// --------------------
`timescale 1ns/1ns
`include "ycr_consts.svh"

module ycr_reset_sync #(
   parameter int unsigned STAGES = `YCR_RST_SYNC_STAGES   // Chain depth, 1 or more
) (
   input  logic core_clk_i,                               // Core clock
   input  logic reset_i,                                  // Raw interface reset
   output logic reset_o                                   // Reset on core clock
);

   logic [STAGES-1:0] sync_chain;                         // Ones shift out on release

   // --------------------
   // Shift chain
   // --------------------
   always_ff @(posedge core_clk_i) begin
      if (reset_i) begin
         sync_chain <= '1;                                // Whole chain set at once
      end else begin
         sync_chain <= sync_chain << 1;                   // Zero walks toward msb
      end
   end

   // Last stage drives the bridge; goes low STAGES cycles after release
   assign reset_o = sync_chain[STAGES-1];

endmodule : ycr_reset_sync

// File: verilog/ycr_dmem_lane.sv
// --------------------
// Byte-lane steering: selects, write replication,
// read alignment and misalignment check
// --------------------
`timescale 1ns/1ns
`include "ycr_consts.svh"

module ycr_dmem_lane (
   input  ycr_pkg::mem_width_e           width_i,       // Access size
   input  logic [1:0]                    addr_lsb_i,    // Byte offset in word
   input  logic [`YCR_DMEM_DWIDTH-1:0]   wdata_i,       // Core store data
   input  logic [`YCR_DMEM_DWIDTH-1:0]   wb_rdata_i,    // Raw bus read word
   output logic [`YCR_WB_SEL_W-1:0]      sel_o,         // Byte selects
   output logic [`YCR_DMEM_DWIDTH-1:0]   wb_wdata_o,    // Replicated store data
   output logic [`YCR_DMEM_DWIDTH-1:0]   rdata_o,       // Aligned load data
   output logic                          misaligned_o   // Access crosses lanes
);
   import ycr_pkg::*;

   dmem_word_u wdata_u;                                 // Store data in
   dmem_word_u wrep_u;                                  // Store data on lanes
   dmem_word_u rraw_u;                                  // Bus word in
   dmem_word_u rout_u;                                  // Load data out

   // --------------------
   // Lane decode
   // --------------------
   always_comb begin
      wdata_u.word = wdata_i;
      rraw_u.word  = wb_rdata_i;
      sel_o        = '0;
      wrep_u.word  = wdata_i;
      rout_u.word  = '0;                                // Upper lanes zero filled
      misaligned_o = 1'b0;
      case (width_i)
         YCR_MEM_WIDTH_BYTE: begin
            sel_o = {{(`YCR_WB_SEL_W-1){1'b0}}, 1'b1} << addr_lsb_i; // One lane
            wrep_u.bytes = {4{wdata_u.bytes[0]}};       // Low byte on every lane
            rout_u.bytes[0] = rraw_u.bytes[addr_lsb_i]; // Selected lane to bit 0
         end
         YCR_MEM_WIDTH_HALF: begin
            sel_o = addr_lsb_i[1] ? 4'b1100 : 4'b0011;  // Upper or lower pair
            wrep_u.bytes = {2{wdata_u.bytes[1], wdata_u.bytes[0]}};
            rout_u.bytes[1:0] = addr_lsb_i[1] ? rraw_u.bytes[3:2]
                                              : rraw_u.bytes[1:0];
            misaligned_o = addr_lsb_i[0];               // Odd half address
         end
         YCR_MEM_WIDTH_WORD: begin
            sel_o = '1;                                 // All lanes
            rout_u.word = rraw_u.word;                  // Passed as is
            misaligned_o = |addr_lsb_i;                 // Any offset is bad
         end
         default: begin
            misaligned_o = 1'b1;                        // Unused width code rejected
         end
      endcase
   end

   // Word view out
   assign wb_wdata_o = wrep_u.word;
   assign rdata_o    = rout_u.word;

endmodule : ycr_dmem_lane

// File: verilog/ycr_dmem_wb.sv
// --------------------
// Data-memory to Wishbone bridge, one blocking
// cycle per core request
// --------------------
`timescale 1ns/1ns
`include "ycr_consts.svh"

module ycr_dmem_wb (
   input  logic                          core_clk_i,        // Core clock
   input  logic                          reset_i,           // Synchronized reset
   input  logic                          dmem_req_i,        // Request level
   input  ycr_pkg::core_req_t            dmem_req_data_i,   // Request payload
   output logic                          dmem_req_ack_o,    // Accept strobe
   output logic [`YCR_DMEM_DWIDTH-1:0]   dmem_rdata_o,      // Aligned load data
   output ycr_pkg::mem_resp_e            dmem_resp_o,       // One cycle response
   output ycr_pkg::wb_req_t              wb_req_o,          // Wishbone master out
   input  ycr_pkg::wb_rsp_t              wb_rsp_i           // Wishbone slave in
);
   import ycr_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE      = 2'd0,                                  // Waiting for request
      ST_BUS       = 2'd1,                                  // Wishbone cycle open
      ST_ERR_REPLY = 2'd2,                                  // Misaligned, no bus cycle
      ST_REPLY     = 2'd3                                   // Bus cycle ended
   } state_e;

   state_e                        state;                    // Current state
   state_e                        state_nxt;                // Next state
   core_req_t                     req_r;                    // Accepted request
   core_req_t                     lane_req;                 // Request seen by lane logic
   logic                          accept;                   // Request taken this cycle
   logic                          bus_done;                 // Slave ended cycle
   logic                          resp_err_r;               // Bus cycle ended in err
   logic                          busy_r;                   // Accepted, response still owed
   logic [`YCR_DMEM_DWIDTH-1:0]   rdata_r;                  // Captured load data
   logic [`YCR_WB_SEL_W-1:0]      lane_sel;
   logic [`YCR_DMEM_DWIDTH-1:0]   lane_wdata;
   logic [`YCR_DMEM_DWIDTH-1:0]   lane_rdata;
   logic                          lane_misaligned;

   // --------------------
   // Lane steering
   // --------------------
   // Idle looks at the incoming request, so misalignment is known at accept
   assign lane_req = (state == ST_IDLE) ? dmem_req_data_i : req_r;

   ycr_dmem_lane u_lane (
      .width_i      (lane_req.width       ),
      .addr_lsb_i   (lane_req.addr[1:0]   ),
      .wdata_i      (lane_req.wdata       ),
      .wb_rdata_i   (wb_rsp_i.dat         ),
      .sel_o        (lane_sel             ),
      .wb_wdata_o   (lane_wdata           ),
      .rdata_o      (lane_rdata           ),
      .misaligned_o (lane_misaligned      )
   );

   // --------------------
   // Control
   // --------------------
   assign accept   = (state == ST_IDLE) && dmem_req_i;    // Only when idle
   assign bus_done = wb_rsp_i.ack || wb_rsp_i.err;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (accept) begin
               state_nxt = lane_misaligned ? ST_ERR_REPLY : ST_BUS;
            end
         end
         ST_BUS: begin
            if (bus_done) begin
               state_nxt = ST_REPLY;                        // Hold until slave ends it
            end
         end
         ST_ERR_REPLY: state_nxt = ST_IDLE;
         ST_REPLY:     state_nxt = ST_IDLE;
         default:      state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge core_clk_i) begin
      if (reset_i) begin
         state      <= ST_IDLE;
         resp_err_r <= 1'b0;
      end else begin
         state <= state_nxt;
         if ((state == ST_BUS) && bus_done) begin
            resp_err_r <= wb_rsp_i.err;                     // err wins over ack
         end
      end
   end

   // Payload capture
   always_ff @(posedge core_clk_i) begin
      if (accept) begin
         req_r <= dmem_req_data_i;
      end
      if ((state == ST_BUS) && bus_done) begin
         rdata_r <= lane_rdata;                             // Already shifted to bit 0
      end
   end

   // --------------------
   // Outputs
   // --------------------
   assign dmem_req_ack_o = accept;
   assign dmem_rdata_o   = rdata_r;

   always_comb begin
      case (state)
         ST_ERR_REPLY: dmem_resp_o = YCR_MEM_RESP_ERR;
         ST_REPLY:     dmem_resp_o = resp_err_r ? YCR_MEM_RESP_ERR : YCR_MEM_RESP_RDY;
         default:      dmem_resp_o = YCR_MEM_RESP_IDLE;
      endcase
   end

   always_comb begin
      wb_req_o.stb = (state == ST_BUS);                     // Rises cycle after ack
      wb_req_o.adr = {req_r.addr[`YCR_DMEM_AWIDTH-1:2], 2'b00}; // Word aligned
      wb_req_o.we  = (req_r.cmd == YCR_MEM_CMD_WR);
      wb_req_o.dat = lane_wdata;
      wb_req_o.sel = lane_sel;
   end

   // --------------------
   // Checks
   // --------------------
   // Set by an accept, cleared once the response has pulsed
   always_ff @(posedge core_clk_i) begin
      if (reset_i) begin
         busy_r <= 1'b0;
      end else if (dmem_req_ack_o) begin
         busy_r <= 1'b1;
      end else if (dmem_resp_o != YCR_MEM_RESP_IDLE) begin
         busy_r <= 1'b0;
      end
   end

   // No second accept until the first request has been answered
   a_no_ack_while_busy : assert property (
      @(posedge core_clk_i) disable iff (reset_i)
      busy_r |-> !dmem_req_ack_o
   );

   // Master holds the cycle unchanged until the slave ends it
   a_stb_stable : assert property (
      @(posedge core_clk_i) disable iff (reset_i)
      (wb_req_o.stb && !bus_done) |=> (wb_req_o.stb && $stable(wb_req_o))
   );

   // Misaligned or bad widths never reach the bus
   a_sel_nonzero : assert property (
      @(posedge core_clk_i) disable iff (reset_i)
      wb_req_o.stb |-> (wb_req_o.sel != '0)
   );

endmodule : ycr_dmem_wb

// File: verilog/ycr_intf.sv
// --------------------
// Interface top: reset synchronizer and
// data-memory Wishbone bridge
// --------------------
`timescale 1ns/1ns
`include "ycr_consts.svh"

module ycr_intf (
   // Clock and reset
   input  logic                          core_clk_i,        // Core clock, also bus clock
   input  logic                          reset_i,           // Interface reset, raw

   // --------------------
   // Core data memory
   // --------------------
   input  logic                          dmem_req_i,        // Request level
   input  ycr_pkg::core_req_t            dmem_req_data_i,   // Cmd, width, addr, wdata
   output logic                          dmem_req_ack_o,    // Accept strobe
   output logic [`YCR_DMEM_DWIDTH-1:0]   dmem_rdata_o,      // Load data
   output ycr_pkg::mem_resp_e            dmem_resp_o,       // Ready or error pulse

   // --------------------
   // Wishbone master
   // --------------------
   output ycr_pkg::wb_req_t              wb_req_o,          // stb, adr, we, dat, sel
   input  ycr_pkg::wb_rsp_t              wb_rsp_i           // dat, ack, err
);

   logic reset_sync;                                        // Reset on core clock

   // --------------------
   // Reset
   // --------------------
   ycr_reset_sync #(
      .STAGES          (`YCR_RST_SYNC_STAGES)
   ) u_rst_sync (
      .core_clk_i      (core_clk_i          ),
      .reset_i         (reset_i             ),
      .reset_o         (reset_sync          )
   );

   // --------------------
   // Data memory bridge
   // --------------------
   ycr_dmem_wb u_dmem_wb (
      .core_clk_i      (core_clk_i          ),
      .reset_i         (reset_sync          ),  // Released clean on core clock
      .dmem_req_i      (dmem_req_i          ),
      .dmem_req_data_i (dmem_req_data_i     ),
      .dmem_req_ack_o  (dmem_req_ack_o      ),
      .dmem_rdata_o    (dmem_rdata_o        ),
      .dmem_resp_o     (dmem_resp_o         ),
      .wb_req_o        (wb_req_o            ),
      .wb_rsp_i        (wb_rsp_i            )
   );

endmodule : ycr_intf

// File: test/tb_wb_mem.sv
// --------------------
// Wishbone slave model: 16-word memory,
// programmable wait states, error address window
// --------------------
`timescale 1ns/1ns
`include "ycr_consts.svh"

module tb_wb_mem (
   input  logic               clk_i,                 // Bus clock
   input  logic [1:0]         wait_i,                // Wait states before ack or err
   input  ycr_pkg::wb_req_t   wb_req_i,              // From the bridge
   output ycr_pkg::wb_rsp_t   wb_rsp_o               // To the bridge
);
   import ycr_pkg::*;

   logic [`YCR_DMEM_DWIDTH-1:0] mem [16];            // Word index from adr[5:2]
   logic [`YCR_DMEM_DWIDTH-1:0] merged;              // Word after byte selects
   logic [`YCR_DMEM_DWIDTH-1:0] dat_r;
   logic [3:0]                  idx;
   logic [1:0]                  wait_cnt;
   logic                        ack_r;
   logic                        err_r;
   logic                        in_err_win;

   initial begin
      // Every word differs, pattern uses the whole index
      for (int i = 0; i < 16; i++) begin
         mem[i] = (32'(i) * 32'h0103_0507) ^ 32'hC0DE_5A00;
      end
      dat_r    = '0;
      wait_cnt = '0;
      ack_r    = 1'b0;
      err_r    = 1'b0;
   end

   assign idx        = wb_req_i.adr[5:2];
   assign in_err_win = wb_req_i.adr[6];              // 0x40..0x7F answers err

   always_comb begin
      merged = mem[idx];
      for (int b = 0; b < 4; b++) begin
         if (wb_req_i.sel[b]) begin
            merged[8*b +: 8] = wb_req_i.dat[8*b +: 8]; // Only selected lanes
         end
      end
   end

   // --------------------
   // Cycle termination
   // --------------------
   always @(posedge clk_i) begin
      if (wb_req_i.stb && !ack_r && !err_r) begin
         if (wait_cnt == wait_i) begin
            wait_cnt <= '0;
            if (in_err_win) begin
               err_r <= 1'b1;                        // No write, no data
               dat_r <= '0;
            end else begin
               ack_r <= 1'b1;
               dat_r <= mem[idx];
               if (wb_req_i.we) begin
                  mem[idx] <= merged;
               end
            end
         end else begin
            wait_cnt <= wait_cnt + 2'd1;             // Still stalling
         end
      end else begin
         ack_r    <= 1'b0;                           // One cycle strobe
         err_r    <= 1'b0;
         wait_cnt <= '0;
      end
   end

   assign wb_rsp_o = {dat_r, ack_r, err_r};

endmodule : tb_wb_mem

// File: test/tb_ycr_intf.sv
// --------------------
// Testbench for the data-memory bridge: LCG stimulus,
// reference memory model, checker and run limit
// --------------------
`timescale 1ns/1ns
`include "ycr_consts.svh"

module tb_ycr_intf;
   import ycr_pkg::*;

   localparam int N_TXN      = 300;
   localparam int MAX_CYCLES = 3000;                 // 300 x 8 cycles worst case plus reset

   logic                          clk;
   logic                          reset;
   logic                          dmem_req;
   core_req_t                     req_data;
   logic                          req_ack;
   logic [`YCR_DMEM_DWIDTH-1:0]   rdata;
   mem_resp_e                     resp;
   wb_req_t                       wb_req;
   wb_rsp_t                       wb_rsp;
   logic [1:0]                    wait_states;       // Slave latency for current txn

   logic [31:0] lcg_state = 32'd24;                  // Fixed seed
   logic [31:0] model_mem [16];                      // Reference copy of slave memory
   int          cycle_cnt = 0;
   int          txn_num   = 0;

   ycr_intf dut0 (
      .core_clk_i      (clk        ),
      .reset_i         (reset      ),
      .dmem_req_i      (dmem_req   ),
      .dmem_req_data_i (req_data   ),
      .dmem_req_ack_o  (req_ack    ),
      .dmem_rdata_o    (rdata      ),
      .dmem_resp_o     (resp       ),
      .wb_req_o        (wb_req     ),
      .wb_rsp_i        (wb_rsp     )
   );

   tb_wb_mem u_wb_mem (
      .clk_i           (clk        ),
      .wait_i          (wait_states),
      .wb_req_i        (wb_req     ),
      .wb_rsp_o        (wb_rsp     )
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                        // 40 ns period
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: test did not end within %0d clock cycles", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $fatal(1, "Run limit reached");
      end
   end

   // --------------------
   // Helpers and model
   // --------------------
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Same fill as the slave memory
   function automatic logic [31:0] fill_word(input int i);
      return (32'(i) * 32'h0103_0507) ^ 32'hC0DE_5A00;
   endfunction

   function automatic logic [3:0] byte_selects(input mem_width_e w, input logic [1:0] off);
      case (w)
         YCR_MEM_WIDTH_BYTE: return 4'b0001 << off;
         YCR_MEM_WIDTH_HALF: return off[1] ? 4'b1100 : 4'b0011;
         default:            return 4'b1111;
      endcase
   endfunction

   function automatic logic [31:0] replicate_wdata(input mem_width_e w, input logic [31:0] d);
      case (w)
         YCR_MEM_WIDTH_BYTE: return {4{d[7:0]}};
         YCR_MEM_WIDTH_HALF: return {2{d[15:0]}};
         default:            return d;
      endcase
   endfunction

   function automatic logic [31:0] extract_load(input logic [31:0] word, input mem_width_e w,
                                                input logic [1:0] off);
      logic [31:0] shifted;
      shifted = word >> {off, 3'b000};               // Selected lanes down to bit 0
      case (w)
         YCR_MEM_WIDTH_BYTE: return shifted & 32'h0000_00FF;
         YCR_MEM_WIDTH_HALF: return shifted & 32'h0000_FFFF;
         default:            return shifted;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERR %s (txn %0d): expected %h actual %h", name, txn_num, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "Mismatch");
      end
   endtask

   // No strobes, no response
   task automatic check_quiet(input string name);
      check_val({name, " req_ack"}, 32'd0, 32'(req_ack));
      check_val({name, " stb"}, 32'd0, 32'(wb_req.stb));
      check_val({name, " resp"}, 32'(YCR_MEM_RESP_IDLE), 32'(resp));
   endtask

   // --------------------
   // One core request
   // --------------------
   task automatic run_txn(input int n);
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      logic [31:0] addr;
      logic [31:0] exp_wdat;
      logic [3:0]  exp_sel;
      logic [5:0]  off6;
      logic [3:0]  idx;
      logic        misal;
      logic        in_err;
      logic        is_wr;
      logic        hold;
      logic        done;
      mem_width_e  w;
      mem_resp_e   exp_resp;
      int          k;
      int          stb_cycles;
      int          bus_ends;
      int          first_stb;
      r1 = next_rand();
      r2 = next_rand();                              // Store data
      r3 = next_rand();
      in_err = (r1[31:29] == 3'd0);                  // About 1 in 8 to the error window
      is_wr  = r1[28];
      w      = mem_width_e'(2'(r1[27:20] % 8'd3));
      off6   = r1[19:14];
      if (r1[13:12] != 2'd0) begin                   // Mostly aligned
         if (w == YCR_MEM_WIDTH_HALF) off6[0] = 1'b0;
         if (w == YCR_MEM_WIDTH_WORD) off6[1:0] = 2'b00;
      end
      hold     = r3[29];                             // Keep req high while busy
      addr     = {25'd0, in_err, off6};
      idx      = off6[5:2];
      misal    = (w == YCR_MEM_WIDTH_HALF && off6[0]) ||
                 (w == YCR_MEM_WIDTH_WORD && off6[1:0] != 2'b00);
      exp_sel  = byte_selects(w, off6[1:0]);
      exp_wdat = replicate_wdata(w, r2);
      exp_resp = (misal || in_err) ? YCR_MEM_RESP_ERR : YCR_MEM_RESP_RDY;
      txn_num  = n;

      @(posedge clk);
      #5;
      wait_states    = r3[31:30];
      req_data.cmd   = is_wr ? YCR_MEM_CMD_WR : YCR_MEM_CMD_RD;
      req_data.width = w;
      req_data.addr  = addr;
      req_data.wdata = r2;
      dmem_req       = 1'b1;
      do begin
         @(negedge clk);
      end while (!req_ack);
      @(posedge clk);
      #5;
      if (!hold) begin
         dmem_req       = 1'b0;
         req_data.addr  = ~addr;                     // Bridge must use its latched copy
         req_data.wdata = ~r2;
      end

      k          = 0;
      stb_cycles = 0;
      bus_ends   = 0;
      first_stb  = 0;
      done       = 1'b0;
      while (!done) begin
         @(negedge clk);
         k++;
         check_val("second req_ack while busy", 32'd0, 32'(req_ack));
         if (wb_req.stb) begin
            if (stb_cycles == 0) begin
               first_stb = k;
               check_val("wb adr", {addr[31:2], 2'b00}, wb_req.adr);
               check_val("wb we", 32'(is_wr), 32'(wb_req.we));
               check_val("wb sel", 32'(exp_sel), 32'(wb_req.sel));
               if (is_wr) check_val("wb dat", exp_wdat, wb_req.dat);
            end
            stb_cycles++;
            if (wb_rsp.ack || wb_rsp.err) bus_ends++;
         end
         done = (resp != YCR_MEM_RESP_IDLE);
      end

      check_val("resp kind", 32'(exp_resp), 32'(resp));
      if (misal) begin
         check_val("misaligned err latency", 32'd1, 32'(k));
         check_val("misaligned stb cycles", 32'd0, 32'(stb_cycles));
      end else begin
         check_val("resp latency", 32'(wait_states) + 32'd3, 32'(k));
         check_val("stb rise", 32'd1, 32'(first_stb));
         check_val("bus cycles", 32'd1, 32'(bus_ends));
      end
      if (!is_wr && exp_resp == YCR_MEM_RESP_RDY) begin
         check_val("rdata", extract_load(model_mem[idx], w, off6[1:0]), rdata);
      end
      if (is_wr && exp_resp == YCR_MEM_RESP_RDY) begin
         for (int b = 0; b < 4; b++) begin
            if (exp_sel[b]) model_mem[idx][8*b +: 8] = exp_wdat[8*b +: 8];
         end
      end

      @(posedge clk);
      #5;
      dmem_req = 1'b0;
      @(negedge clk);
      check_quiet("after resp");                     // Response lasts one cycle
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      reset       = 1'b1;
      dmem_req    = 1'b0;
      req_data    = '0;
      wait_states = 2'd0;
      for (int i = 0; i < 16; i++) begin
         model_mem[i] = fill_word(i);
      end
      repeat (10) @(posedge clk);
      #5;
      reset = 1'b0;
      repeat (6) begin
         @(negedge clk);
         check_quiet("after reset");
      end
      for (int n = 0; n < N_TXN; n++) begin
         run_txn(n);
      end
      $display("Ran %0d transactions in %0d cycles", N_TXN, cycle_cnt);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule : tb_ycr_intf

// File: sim.f
+incdir+verilog
verilog/ycr_pkg.sv
verilog/ycr_reset_sync.sv
verilog/ycr_dmem_lane.sv
verilog/ycr_dmem_wb.sv
verilog/ycr_intf.sv
test/tb_wb_mem.sv
test/tb_ycr_intf.sv

// File: run.sh
#!/bin/sh
# Build and run the data-memory bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
   -f sim.f \
   --top-module tb_ycr_intf \
   -o tb_ycr_intf

# Result is read from the log
./obj_dir/tb_ycr_intf 2>&1 | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
   echo "Result: failed"
   exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
   echo "Result: no pass line in $LOG"
   exit 1
fi
echo "Result: passed"
